//--- design/t04Pkg.sv
package t04Pkg;

  // one display byte entry: dcx flag on top, byte below
  localparam int entryW = 9;

  // digit reading of a key code
  typedef struct packed {
    logic       isFunc;
    logic [3:0] value;
  } keyDigitT;

  // function reading of a key code
  typedef struct packed {
    logic       isFunc;
    logic [3:0] op;
  } keyFuncT;

  // isFunc picks which reading applies
  typedef union packed {
    keyDigitT digit;
    keyFuncT  func;
  } keyCodeT;

  // function ops, others ignored by the editor
  localparam logic [3:0] funcClear     = 4'd0;
  localparam logic [3:0] funcBackspace = 4'd1;
  localparam logic [3:0] funcEnter     = 4'd2;

  // display controller opcodes
  localparam logic [7:0] opClearScreen = 8'h01;
  localparam logic [7:0] opColumnSet   = 8'h2A;
  localparam logic [7:0] opRowSet      = 8'h2B;
  localparam logic [7:0] opMemWrite    = 8'h2C;

  // character codes
  localparam logic [7:0] asciiZero  = 8'h30;
  localparam logic [7:0] asciiSpace = 8'h20;

endpackage

//--- design/keypadScanner.sv
`timescale 1ns/1ps
`default_nettype none

module keypadScanner #(
  parameter int DEBOUNCE = 4
) (
  input  logic            hz100,
  input  logic            arstN,
  input  logic [3:0]      row,
  output logic [3:0]      column,
  output logic            keyValid,
  input  logic            keyReady,
  output t04Pkg::keyCodeT keyCode
);
  import t04Pkg::*;

  localparam int cntW = $clog2(DEBOUNCE + 1);

  // column currently strobed low
  logic [1:0]      colIdx;
  // partial snapshot, filled one column per cycle
  logic [15:0]     roundAcc;
  logic [15:0]     roundNow;
  logic [15:0]     prevRound;
  logic [cntW-1:0] stableCnt;
  logic [cntW-1:0] nextCnt;
  // cleared once a press fires, set by an empty round
  logic            armed;
  logic            roundEnd;
  logic            singleKey;
  logic            fire;
  logic            pending;
  logic [3:0]      keyPos;

  // position to key code lookup
  function automatic keyCodeT posToKey(input logic [3:0] pos);
    keyCodeT code;
    code.func.isFunc = 1'b1;
    case (pos)
      4'd10:   code.func.op = funcClear;
      4'd11:   code.func.op = funcBackspace;
      4'd12:   code.func.op = funcEnter;
      4'd13:   code.func.op = 4'd3;
      4'd14:   code.func.op = 4'd4;
      4'd15:   code.func.op = 4'd5;
      default: begin
        code.digit.isFunc = 1'b0;
        code.digit.value  = pos;
      end
    endcase
    return code;
  endfunction

  // one-hot low strobe
  assign column = ~(4'b0001 << colIdx);

  // merge this cycle's row sample into the snapshot
  always_comb begin
    roundNow = roundAcc;
    for (int r = 0; r < 4; r++) begin
      roundNow[r * 4 + int'(colIdx)] = ~row[r];
    end
  end

  // snapshot complete on the last column
  assign roundEnd  = (colIdx == 2'd3);
  assign singleKey = (roundNow != 16'd0) && ((roundNow & (roundNow - 16'd1)) == 16'd0);

  // stability count over whole rounds, saturates at DEBOUNCE
  always_comb begin
    if (!singleKey) begin
      nextCnt = '0;
    end else if (roundNow != prevRound) begin
      nextCnt = cntW'(1);
    end else if (stableCnt != cntW'(DEBOUNCE)) begin
      nextCnt = stableCnt + cntW'(1);
    end else begin
      nextCnt = stableCnt;
    end
  end

  // index of the single pressed key
  always_comb begin
    keyPos = 4'd0;
    for (int p = 0; p < 16; p++) begin
      if (roundNow[p]) keyPos = 4'(p);
    end
  end

  assign fire    = roundEnd && armed && singleKey && (nextCnt == cntW'(DEBOUNCE));
  // a key still waiting for the editor
  assign pending = keyValid && !keyReady;

  always_ff @(posedge hz100 or negedge arstN) begin
    if (!arstN) begin
      colIdx    <= 2'd0;
      prevRound <= 16'd0;
      stableCnt <= '0;
      armed     <= 1'b1;
      keyValid  <= 1'b0;
    end else begin
      colIdx <= colIdx + 2'd1;
      if (keyValid && keyReady) keyValid <= 1'b0;
      if (roundEnd) begin
        prevRound <= roundNow;
        stableCnt <= nextCnt;
        if (roundNow == 16'd0) begin
          armed <= 1'b1;
        end else if (fire) begin
          armed <= 1'b0;
        end
        // press is dropped if one is still pending
        if (fire && !pending) keyValid <= 1'b1;
      end
    end
  end

  always_ff @(posedge hz100) begin
    roundAcc <= roundNow;
    if (fire && !pending) keyCode <= posToKey(keyPos);
  end

endmodule

`default_nettype wire

//--- design/keyEntryEditor.sv
`timescale 1ns/1ps
`default_nettype none

module keyEntryEditor #(
  parameter int COLS = 16,
  parameter int ROWS = 4
) (
  input  logic                      hz100,
  input  logic                      arstN,
  input  logic                      keyValid,
  output logic                      keyReady,
  input  t04Pkg::keyCodeT           keyCode,
  output logic                      entryValid,
  output logic [t04Pkg::entryW-1:0] entry,
  input  logic                      entryReady
);
  import t04Pkg::*;

  localparam int colW = (COLS > 1) ? $clog2(COLS) : 1;
  localparam int rowW = (ROWS > 1) ? $clog2(ROWS) : 1;

  // text cursor
  logic [colW-1:0] curCol;
  logic [rowW-1:0] curRow;
  logic [rowW-1:0] nextRow;
  // position and glyph of the sequence in flight
  logic [colW-1:0] seqCol;
  logic [rowW-1:0] seqRow;
  logic [7:0]      charByte;
  // index into the six-entry write sequence
  logic [2:0]      step;
  logic            busy;
  // single-entry clear sequence
  logic            isClear;
  logic            lastStep;
  logic            keyTake;
  logic            entryTake;

  assign keyReady   = !busy;
  assign entryValid = busy;
  assign keyTake    = keyValid && keyReady;
  assign entryTake  = entryValid && entryReady;
  assign lastStep   = isClear || (step == 3'd5);

  // row after the cursor row wrapping at ROWS
  assign nextRow = (curRow == rowW'(ROWS - 1)) ? '0 : curRow + rowW'(1);

  always_ff @(posedge hz100 or negedge arstN) begin
    if (!arstN) begin
      curCol  <= '0;
      curRow  <= '0;
      step    <= 3'd0;
      busy    <= 1'b0;
      isClear <= 1'b0;
    end else begin
      if (entryTake) begin
        if (lastStep) begin
          busy <= 1'b0;
          step <= 3'd0;
        end else begin
          step <= step + 3'd1;
        end
      end
      if (keyTake) begin
        if (!keyCode.digit.isFunc) begin
          // digit writes then advances with a wrap onto the next row
          busy    <= 1'b1;
          isClear <= 1'b0;
          if (curCol == colW'(COLS - 1)) begin
            curCol <= '0;
            curRow <= nextRow;
          end else begin
            curCol <= curCol + colW'(1);
          end
        end else begin
          case (keyCode.func.op)
            funcBackspace: begin
              // nothing to erase at column 0
              if (curCol != '0) begin
                busy    <= 1'b1;
                isClear <= 1'b0;
                curCol  <= curCol - colW'(1);
              end
            end
            funcClear: begin
              busy    <= 1'b1;
              isClear <= 1'b1;
              curCol  <= '0;
              curRow  <= '0;
            end
            funcEnter: begin
              // cursor move only with no bus traffic
              curCol <= '0;
              curRow <= nextRow;
            end
            default: begin
              // remaining ops leave cursor and bus alone
            end
          endcase
        end
      end
    end
  end

  // sequence payload latched at key accept
  always_ff @(posedge hz100) begin
    if (keyTake) begin
      seqRow <= curRow;
      if (keyCode.func.isFunc) begin
        // backspace blanks the cell left of the cursor
        seqCol   <= curCol - colW'(1);
        charByte <= asciiSpace;
      end else begin
        seqCol   <= curCol;
        charByte <= asciiZero + {4'd0, keyCode.digit.value};
      end
    end
  end

  // entry for the current step with the dcx flag on top
  always_comb begin
    if (isClear) begin
      entry = {1'b0, opClearScreen};
    end else begin
      case (step)
        3'd0:    entry = {1'b0, opColumnSet};
        3'd1:    entry = {1'b1, 8'(seqCol)};
        3'd2:    entry = {1'b0, opRowSet};
        3'd3:    entry = {1'b1, 8'(seqRow)};
        3'd4:    entry = {1'b0, opMemWrite};
        default: entry = {1'b1, charByte};
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/screenWriter.sv
`timescale 1ns/1ps
`default_nettype none

module screenWriter (
  input  logic                      hz100,
  input  logic                      arstN,
  input  logic                      entryValid,
  output logic                      entryReady,
  input  logic [t04Pkg::entryW-1:0] entry,
  output logic                      screenCsx,
  output logic                      screenDcx,
  output logic                      screenWrx,
  output logic [7:0]                screenData
);
  import t04Pkg::*;

  // idle doubles as the wrx-high latch cycle
  localparam logic [1:0] phIdle   = 2'd0;
  localparam logic [1:0] phSetup  = 2'd1;
  localparam logic [1:0] phStrobe = 2'd2;

  logic [1:0] phase;
  logic       take;

  assign entryReady = (phase == phIdle);
  assign take       = entryValid && entryReady;

  always_ff @(posedge hz100 or negedge arstN) begin
    if (!arstN) begin
      phase      <= phIdle;
      screenCsx  <= 1'b1;
      screenWrx  <= 1'b1;
      screenDcx  <= 1'b1;
      screenData <= 8'd0;
    end else begin
      case (phase)
        phIdle: begin
          if (take) begin
            // select chip, present dcx and byte
            phase      <= phSetup;
            screenCsx  <= 1'b0;
            screenDcx  <= entry[entryW-1];
            screenData <= entry[entryW-2:0];
          end else begin
            // deselect only when nothing is queued
            screenCsx <= 1'b1;
          end
        end
        phSetup: begin
          screenWrx <= 1'b0;
          phase     <= phStrobe;
        end
        phStrobe: begin
          // rising wrx latches the byte
          screenWrx <= 1'b1;
          phase     <= phIdle;
        end
        default: begin
          phase <= phIdle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/t04Top.sv
`timescale 1ns/1ps
`default_nettype none

module t04Top #(
  parameter int DEBOUNCE = 4,
  parameter int COLS     = 16,
  parameter int ROWS     = 4
) (
  input  logic       hz100,
  input  logic       arstN,
  input  logic [3:0] row,
  output logic [3:0] column,
  output logic       screenCsx,
  output logic       screenDcx,
  output logic       screenWrx,
  output logic [7:0] screenData
);
  import t04Pkg::*;

  // scanner to editor
  logic              keyValid;
  logic              keyReady;
  keyCodeT           keyCode;
  // editor to writer
  logic              entryValid;
  logic              entryReady;
  logic [entryW-1:0] entry;

  // keypad scan and debounce
  keypadScanner #(
    .DEBOUNCE(DEBOUNCE)
  ) scanner (
    .hz100   (hz100),
    .arstN   (arstN),
    .row     (row),
    .column  (column),
    .keyValid(keyValid),
    .keyReady(keyReady),
    .keyCode (keyCode)
  );

  // cursor and byte sequences
  keyEntryEditor #(
    .COLS(COLS),
    .ROWS(ROWS)
  ) editor (
    .hz100     (hz100),
    .arstN     (arstN),
    .keyValid  (keyValid),
    .keyReady  (keyReady),
    .keyCode   (keyCode),
    .entryValid(entryValid),
    .entry     (entry),
    .entryReady(entryReady)
  );

  // 8080 write cycles
  screenWriter writer (
    .hz100     (hz100),
    .arstN     (arstN),
    .entryValid(entryValid),
    .entryReady(entryReady),
    .entry     (entry),
    .screenCsx (screenCsx),
    .screenDcx (screenDcx),
    .screenWrx (screenWrx),
    .screenData(screenData)
  );

endmodule

`default_nettype wire

//--- test/t04TopChecker_checker.sv
`timescale 1ns/1ps

module t04TopChecker (
  input logic                      hz100,
  input logic                      arstN,
  input logic [3:0]                column,
  input logic                      keyValid,
  input logic                      keyReady,
  input t04Pkg::keyCodeT           keyCode,
  input logic                      entryValid,
  input logic                      entryReady,
  input logic [t04Pkg::entryW-1:0] entry,
  input logic                      screenCsx,
  input logic                      screenDcx,
  input logic                      screenWrx,
  input logic [7:0]                screenData
);

  // write strobe only with chip selected
  wrxUnderCs: assert property (@(posedge hz100) disable iff (!arstN)
    $fell(screenWrx) |-> !screenCsx)
    else $error("screenWrx fell while screenCsx was high");

  // dcx and data frozen through the low strobe
  busStable: assert property (@(posedge hz100) disable iff (!arstN)
    !screenWrx |-> $stable({screenDcx, screenData}))
    else $error("screenDcx or screenData moved while screenWrx was low");

  keyHeld: assert property (@(posedge hz100) disable iff (!arstN)
    keyValid && !keyReady |=> keyValid && $stable(keyCode))
    else $error("key code dropped or changed before transfer");

  entryHeld: assert property (@(posedge hz100) disable iff (!arstN)
    entryValid && !entryReady |=> entryValid && $stable(entry))
    else $error("display entry dropped or changed before transfer");

  // exactly one column strobed low
  colOneHot: assert property (@(posedge hz100) disable iff (!arstN)
    $onehot(~column))
    else $error("column strobe is not one-hot low");

endmodule

bind t04Top t04TopChecker busChecks (
  .hz100     (hz100),
  .arstN     (arstN),
  .column    (column),
  .keyValid  (keyValid),
  .keyReady  (keyReady),
  .keyCode   (keyCode),
  .entryValid(entryValid),
  .entryReady(entryReady),
  .entry     (entry),
  .screenCsx (screenCsx),
  .screenDcx (screenDcx),
  .screenWrx (screenWrx),
  .screenData(screenData)
);

//--- test/t04TopTb.sv
`timescale 1ns/1ps

module t04TopTb;

  localparam int DEBOUNCE  = 4;
  localparam int COLS      = 16;
  localparam int ROWS      = 4;
  // shortest hold that always spans DEBOUNCE full rounds
  localparam int minRounds = DEBOUNCE + 2;
  localparam int gapRounds = 10;

  logic       hz100;
  logic       arstN;
  logic [3:0] row = 4'hF;
  logic [3:0] column;
  logic       screenCsx;
  logic       screenDcx;
  logic       screenWrx;
  logic [7:0] screenData;

  // golden words with the press count first and then each press record
  logic [11:0] gold [0:255];
  // {dcx, byte} still owed by the display bus
  logic [8:0]  expq [$];
  logic [7:0]  lfsr = 8'd21;
  logic        keyDown = 1'b0;
  logic [3:0]  keyPos = 4'd0;
  int          cycles = 0;
  int          cycleLimit = 0;

  t04Top #(
    .DEBOUNCE(DEBOUNCE),
    .COLS    (COLS),
    .ROWS    (ROWS)
  ) dut (
    .hz100     (hz100),
    .arstN     (arstN),
    .row       (row),
    .column    (column),
    .screenCsx (screenCsx),
    .screenDcx (screenDcx),
    .screenWrx (screenWrx),
    .screenData(screenData)
  );

  initial begin
    hz100 = 1'b0;
    forever #10 hz100 = ~hz100;
  end

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic checkEq(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
    if (expected !== actual) begin
      stopOnError($sformatf("mismatch at %0t: %s expected %h actual %h",
                            $time, name, expected, actual));
    end
  endtask

  // taps x^8 + x^6 + x^5 + x^4 with shifts toward the msb
  function automatic logic [7:0] lfsrStep(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // hold length of one to three times the minimum
  task automatic pickHold(output int rounds);
    int pick;
    pick = 0;
    for (int b = 0; b < 2; b++) begin
      pick = pick * 2 + int'(lfsr[7]);
      lfsr = lfsrStep(lfsr);
    end
    rounds = minRounds * (1 + pick % 3);
  endtask

  // pressed switch pulls its row low while its column is strobed
  function automatic logic [3:0] rowLines(input logic [3:0] col, input logic down,
                                          input logic [3:0] pos);
    logic [3:0] r;
    r = 4'hF;
    if (down && !col[pos[1:0]]) r[pos[3:2]] = 1'b0;
    return r;
  endfunction

  // keypad model
  always @(posedge hz100) begin
    #1;
    row = rowLines(column, keyDown, keyPos);
  end

  // bus monitor latching the byte on rising wrx
  always @(posedge screenWrx) begin
    if (arstN === 1'b1 && screenCsx === 1'b0) begin
      if (expq.size() == 0) begin
        stopOnError($sformatf("unexpected display write at %0t", $time));
      end else begin
        checkEq("screen {dcx,data}", 16'(expq.pop_front()), 16'({screenDcx, screenData}));
      end
    end
  end

  always @(posedge hz100) begin
    cycles = cycles + 1;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      stopOnError("timeout: display writes did not finish");
    end
  end

  initial begin
    int nPress;
    int idx;
    int cnt;
    int hold;
    arstN = 1'b0;
    $readmemh("test/keyGolden.txt", gold);
    nPress     = int'(gold[0]);
    cycleLimit = nPress * 200 + 500;
    repeat (15) @(posedge hz100);
    // reset values while still held
    @(negedge hz100);
    checkEq("column", 16'(4'b1110), 16'(column));
    checkEq("screenCsx", 16'(1'b1), 16'(screenCsx));
    checkEq("screenWrx", 16'(1'b1), 16'(screenWrx));
    checkEq("screenDcx", 16'(1'b1), 16'(screenDcx));
    checkEq("screenData", 16'(8'h00), 16'(screenData));
    @(posedge hz100);
    #1;
    arstN = 1'b1;
    // quiet bus before the first press
    repeat (gapRounds * 4) begin
      @(negedge hz100);
      checkEq("screenCsx", 16'(1'b1), 16'(screenCsx));
      checkEq("screenWrx", 16'(1'b1), 16'(screenWrx));
    end
    idx = 1;
    for (int p = 0; p < nPress; p++) begin
      keyPos = gold[idx][3:0];
      cnt    = int'(gold[idx + 1]);
      // previous press fully written
      do @(negedge hz100); while (expq.size() != 0);
      for (int k = 0; k < cnt; k++) begin
        expq.push_back(gold[idx + 2 + k][8:0]);
      end
      idx = idx + 2 + cnt;
      pickHold(hold);
      @(posedge hz100);
      keyDown = 1'b1;
      repeat (hold * 4) @(posedge hz100);
      keyDown = 1'b0;
      repeat (gapRounds * 4) @(posedge hz100);
    end
    do @(negedge hz100); while (expq.size() != 0 || screenCsx !== 1'b1);
    checkEq("screenWrx", 16'(1'b1), 16'(screenWrx));
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- test/keyGolden.txt
// first word: number of presses, then one press per line
// key position, entry count, entries as {dcx, byte} in hex
01E
7 6 02A 100 02B 100 02C 137
3 6 02A 101 02B 100 02C 133
B 6 02A 101 02B 100 02C 120
C 0
B 0
E 0
5 6 02A 100 02B 101 02C 135
A 1 001
9 6 02A 100 02B 100 02C 139
C 0
C 0
C 0
0 6 02A 100 02B 103 02C 130
1 6 02A 101 02B 103 02C 131
2 6 02A 102 02B 103 02C 132
3 6 02A 103 02B 103 02C 133
4 6 02A 104 02B 103 02C 134
5 6 02A 105 02B 103 02C 135
6 6 02A 106 02B 103 02C 136
7 6 02A 107 02B 103 02C 137
8 6 02A 108 02B 103 02C 138
9 6 02A 109 02B 103 02C 139
0 6 02A 10A 02B 103 02C 130
1 6 02A 10B 02B 103 02C 131
2 6 02A 10C 02B 103 02C 132
3 6 02A 10D 02B 103 02C 133
4 6 02A 10E 02B 103 02C 134
5 6 02A 10F 02B 103 02C 135
8 6 02A 100 02B 100 02C 138
F 0

//--- flist.f
design/t04Pkg.sv
design/keypadScanner.sv
design/keyEntryEditor.sv
design/screenWriter.sv
design/t04Top.sv
test/t04TopChecker_checker.sv
test/t04TopTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= t04TopTb
FLIST     ?= flist.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
